// ==== vlog.f ====
hdl/buff_sched_pkg.sv
hdl/buff_use_decoder.sv
hdl/sched_fsm.sv
hdl/step_counter.sv
hdl/buff_accum_bank.sv
hdl/buff_sched_top.sv
bench/buff_sched_asserts.sv
bench/buff_sched_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run buff_sched_tb with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module buff_sched_tb -Mdir obj_dir -f vlog.f
	./obj_dir/Vbuff_sched_tb

clean:
	rm -rf obj_dir

// ==== bench/buff_sched_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module buff_sched_tb import buff_sched_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 64;
    // independent copy of the schedule, mask per step 0..25
    localparam buff_mask_t MASK_TABLE [26] = '{
        4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h8, 4'hC, 4'h6, 4'h2, 4'h9, 4'hD, 4'h8, 4'hE,
        4'h4, 4'h6, 4'h0, 4'h3, 4'hB, 4'h1, 4'hD, 4'h8, 4'hC, 4'h2, 4'h3, 4'h9, 4'h8
    };

    logic       clk;
    logic       rst;
    logic       start;
    sample_t    sample;
    logic       busy;
    logic       done;
    buff_mask_t buff_use;
    step_t      step;
    acc_set_t   sums;

    integer     seed;
    // expected sums of the run in flight
    acc_set_t   exp_sums;

    buff_sched_top buff_sched_top_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .sample   (sample),
        .busy     (busy),
        .done     (done),
        .buff_use (buff_use),
        .step     (step),
        .sums     (sums)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %0d ns: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_step(input step_t got, input step_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %0d ns: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_mask(input buff_mask_t got, input buff_mask_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %0d ns: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_sums(input acc_set_t got, input acc_set_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %0d ns: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("ERROR %0d ns: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    // model of one step, buffer i takes the sample when mask bit i is set
    function automatic acc_set_t add_sample(acc_set_t s, buff_mask_t m, sample_t v);
        acc_set_t r;
        r = s;
        if (m[0]) r.acc0 = s.acc0 + acc_t'(v);
        if (m[1]) r.acc1 = s.acc1 + acc_t'(v);
        if (m[2]) r.acc2 = s.acc2 + acc_t'(v);
        if (m[3]) r.acc3 = s.acc3 + acc_t'(v);
        return r;
    endfunction

    // one full schedule, checks step and mask each run cycle, then the sums at done
    task automatic run_schedule(input bit use_random, input bit poke_start);
        int      n;
        int      cyc;
        sample_t smp;
        n = 0;
        cyc = 0;
        exp_sums = '0;
        @(negedge clk);
        check_bit(busy, 1'b0, "busy before start");
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // wait for done, one sample per run cycle
        while (!done && cyc < TIMEOUT_CYCLES) begin
            if (n > int'(LAST_STEP)) begin
                abort_run("schedule kept running past its last step without done");
            end
            check_bit(busy, 1'b1, "busy in run cycle");
            check_step(step, step_t'(n), "step in run cycle");
            check_mask(buff_use, MASK_TABLE[n], "buff_use in run cycle");
            smp = use_random ? sample_t'($random(seed)) : sample_t'(n);
            sample = smp;
            exp_sums = add_sample(exp_sums, MASK_TABLE[n], smp);
            n++;
            // extra start pulses in mid run must be ignored
            start = poke_start && (n == 9 || n == 20);
            cyc++;
            @(negedge clk);
        end
        start = 1'b0;
        if (!done) begin
            abort_run("timed out waiting for done");
        end
        // done in the 27th cycle after the start edge
        check_count(n, int'(LAST_STEP) + 1, "run cycles before done");
        check_bit(busy, 1'b1, "busy at done");
        check_step(step, '0, "step at done");
        check_sums(sums, exp_sums, "sums at done");
        @(negedge clk);
        check_bit(done, 1'b0, "done after its pulse");
        check_bit(busy, 1'b0, "busy after done");
        check_sums(sums, exp_sums, "sums held in idle");
    endtask

    task automatic test_reset_values();
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(done, 1'b0, "done after reset");
        check_step(step, '0, "step after reset");
        check_mask(buff_use, '0, "buff_use after reset");
        check_sums(sums, '0, "sums after reset");
    endtask

    task automatic test_step_pattern();
        run_schedule(1'b0, 1'b0);
    endtask

    task automatic test_random_sums();
        run_schedule(1'b1, 1'b0);
    endtask

    task automatic test_start_while_busy();
        run_schedule(1'b1, 1'b1);
    endtask

    // second run must show only its own samples
    task automatic test_back_to_back();
        run_schedule(1'b1, 1'b0);
        run_schedule(1'b1, 1'b0);
    endtask

    initial begin
        seed = 32'hfd605daa;
        rst = 1'b1;
        start = 1'b0;
        sample = '0;
        exp_sums = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset_values();
        test_step_pattern();
        test_random_sums();
        test_start_while_busy();
        test_back_to_back();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/buff_sched_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module buff_sched_asserts import buff_sched_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       start,
    input logic       busy,
    input logic       done,
    input step_t      step,
    input buff_mask_t buff_use
);

    // done is a single pulse and the fsm is idle right after
    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> (!done && !busy))
        else $error("done held for more than one cycle or busy stayed high after it");

    // counter never leaves the schedule range
    step_range: assert property (@(posedge clk) disable iff (rst)
        step <= LAST_STEP)
        else $error("step went beyond the last schedule step");

    // an accepted start always launches a run
    start_busy: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |=> busy)
        else $error("start in idle did not raise busy");

    // idle rests at step 0, which decodes to an empty mask
    idle_mask: assert property (@(posedge clk) disable iff (rst)
        !busy |-> (buff_use == '0))
        else $error("buff_use not empty while idle");

endmodule

bind buff_sched_top buff_sched_asserts buff_sched_asserts_i (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .step     (step),
    .buff_use (buff_use)
);

`default_nettype wire

// ==== hdl/buff_sched_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module buff_sched_top import buff_sched_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  sample_t    sample,
    output logic       busy,
    output logic       done,
    output buff_mask_t buff_use,
    output step_t      step,
    output acc_set_t   sums
);

    // controller outputs to counter and bank
    sched_ctrl_t ctrl;
    // final step flag back to the controller
    logic        last;

    sched_fsm sched_fsm_i (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .last  (last),
        .ctrl  (ctrl),
        .busy  (busy),
        .done  (done)
    );

    step_counter step_counter_i (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl),
        .step (step),
        .last (last)
    );

    // step to mask, purely combinational
    buff_use_decoder buff_use_decoder_i (
        .step     (step),
        .buff_use (buff_use)
    );

    buff_accum_bank buff_accum_bank_i (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .buff_use (buff_use),
        .sample   (sample),
        .sums     (sums)
    );

endmodule

`default_nettype wire

// ==== hdl/buff_accum_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module buff_accum_bank import buff_sched_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  sched_ctrl_t ctrl,
    input  buff_mask_t  buff_use,
    input  sample_t     sample,
    output acc_set_t    sums
);

    // one running sum per buffer
    acc_t acc_q [NUM_BUFF];

    // zero-extended sample for the adders
    acc_t sample_ext;

    assign sample_ext = acc_t'(sample);

    always_ff @(posedge clk) begin
        if (rst || ctrl.clear) begin
            // sums must read zero after reset as well as on start
            for (int i = 0; i < NUM_BUFF; i++) begin
                acc_q[i] <= '0;
            end
        end else if (ctrl.run) begin
            // each enabled buffer takes this cycle's sample
            for (int i = 0; i < NUM_BUFF; i++) begin
                if (buff_use[i]) begin
                    acc_q[i] <= acc_q[i] + sample_ext;
                end
            end
        end
    end

    // hold value otherwise, sums stay readable after done

    // pack the array into the output struct
    assign sums.acc0 = acc_q[0];
    assign sums.acc1 = acc_q[1];
    assign sums.acc2 = acc_q[2];
    assign sums.acc3 = acc_q[3];

endmodule

`default_nettype wire

// ==== hdl/step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_counter import buff_sched_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  sched_ctrl_t ctrl,
    output step_t       step,
    output logic        last
);

    // count run cycles, rest at 0 otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (!ctrl.run) begin
            step <= '0;
        end else if (last) begin
            // wrap together with the fsm leaving run
            step <= '0;
        end else begin
            step <= step + 5'd1;
        end
    end

    // the one compare against the schedule end
    assign last = (step == LAST_STEP);

endmodule

`default_nettype wire

// ==== hdl/sched_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_fsm import buff_sched_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        last,
    output sched_ctrl_t ctrl,
    output logic        busy,
    output logic        done
);

    sched_state_t state;
    sched_state_t state_nxt;

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // start only counts here, ignored while busy
                if (start) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                // leave after the last step has been accumulated
                if (last) begin
                    state_nxt = st_done;
                end
            end
            st_done: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // clear fires in the idle cycle that sees start
    assign ctrl.clear = (state == st_idle) && start;
    assign ctrl.run   = (state == st_run);

    // busy spans run plus the single done cycle
    assign busy = (state != st_idle);
    assign done = (state == st_done);

endmodule

`default_nettype wire

// ==== hdl/buff_use_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module buff_use_decoder import buff_sched_pkg::*; (
    input  step_t      step,
    output buff_mask_t buff_use
);

    // complemented step bits
    step_t step_n;

    // product terms per mask bit
    logic [8:0] product3;
    logic [6:0] product2;
    logic [4:0] product1;
    logic [4:0] product0;

    // partial sums per mask bit
    logic [2:0] sum3;
    logic [1:0] sum2;
    logic [1:0] sum1;
    logic [1:0] sum0;

    // final sop value per mask bit
    logic [NUM_BUFF-1:0] sum;

    assign step_n = ~step;

    // bit 3 covers steps 5 6 9 10 11 12 17 19 20 21 24 25
    assign product3[0] = step_n[4] & step[3]   & step[2]   & step_n[1] & step_n[0]; // 01100
    assign product3[1] = step[4]   & step[3]   & step_n[2] & step_n[1] & step_n[0]; // 11000
    assign product3[2] = step_n[4] & step_n[3] & step[2]   & step[1]   & step_n[0]; // 00110
    assign product3[3] = step[4]   & step_n[3] & step_n[2] & step[1]   & step[0];   // 10011
    assign product3[4] = step_n[4] & step[3]   & step_n[2] & step[1]   & step_n[0]; // 01010
    assign product3[5] = step_n[4] & step[3]   & step_n[2] & step[0];               // 010-1
    assign product3[6] = step[4]   & step_n[2] & step_n[1] & step[0];               // 1-001
    assign product3[7] = step_n[3] & step[2]   & step_n[1] & step[0];               // -0101
    assign product3[8] = step[4]   & step_n[3] & step[2]   & step_n[1];             // 1010-

    // three groups of three, then one more or
    assign sum3[0] = |product3[2:0];
    assign sum3[1] = |product3[5:3];
    assign sum3[2] = |product3[8:6];
    assign sum[3]  = |sum3;

    // bit 2 covers steps 6 7 10 12 13 14 19 21
    assign product2[0] = step[4]   & step_n[3] & step[2]   & step_n[1] & step[0];   // 10101
    assign product2[1] = step_n[4] & step_n[3] & step[2]   & step[1]   & step[0];   // 00111
    assign product2[2] = step_n[4] & step_n[3] & step[2]   & step[1]   & step_n[0]; // 00110
    assign product2[3] = step[4]   & step_n[3] & step_n[2] & step[1]   & step[0];   // 10011
    assign product2[4] = step_n[4] & step[3]   & step_n[2] & step[1]   & step_n[0]; // 01010
    assign product2[5] = step_n[4] & step[3]   & step[2]   & step_n[1];             // 0110-
    assign product2[6] = step_n[4] & step[3]   & step[2]   & step_n[0];             // 011-0

    assign sum2[0] = |product2[3:0];
    assign sum2[1] = |product2[6:4];
    assign sum[2]  = sum2[0] | sum2[1];

    // bit 1 covers steps 7 8 12 14 16 17 22 23
    assign product1[0] = step_n[4] & step_n[3] & step[2]   & step[1]   & step[0];   // 00111
    assign product1[1] = step_n[4] & step[3]   & step_n[1] & step_n[0];             // 01-00
    assign product1[2] = step[4]   & step_n[3] & step[2]   & step[1];               // 1011-
    assign product1[3] = step[4]   & step_n[3] & step_n[2] & step_n[1];             // 1000-
    assign product1[4] = step_n[4] & step[3]   & step[2]   & step_n[0];             // 011-0

    assign sum1[0] = |product1[2:0];
    assign sum1[1] = product1[3] | product1[4];
    assign sum[1]  = sum1[0] | sum1[1];

    // bit 0 covers steps 9 10 16 17 18 19 23 24
    assign product0[0] = step_n[4] & step[3]   & step_n[2] & step_n[1] & step[0];   // 01001
    assign product0[1] = step[4]   & step[3]   & step_n[2] & step_n[1] & step_n[0]; // 11000
    assign product0[2] = step[4]   & step_n[3] & step[1]   & step[0];               // 10-11
    assign product0[3] = step_n[4] & step[3]   & step_n[2] & step[1]   & step_n[0]; // 01010
    assign product0[4] = step[4]   & step_n[3] & step_n[2];                         // 100--

    assign sum0[0] = |product0[2:0];
    assign sum0[1] = product0[3] | product0[4];
    assign sum[0]  = sum0[0] | sum0[1];

    // no term hits steps 26 to 31, so those give an empty mask
    assign buff_use = sum;

endmodule

`default_nettype wire

// ==== hdl/buff_sched_pkg.sv ====
`default_nettype none

package buff_sched_pkg;

    // field widths
    localparam int STEP_W   = 5;
    localparam int SAMPLE_W = 8;
    localparam int ACC_W    = 16;

    // buffer count, also the mask width
    localparam int NUM_BUFF = 4;

    typedef logic [STEP_W-1:0]   step_t;
    typedef logic [NUM_BUFF-1:0] buff_mask_t;
    typedef logic [SAMPLE_W-1:0] sample_t;
    // 26 x 255 fits easily in 16 bits
    typedef logic [ACC_W-1:0]    acc_t;

    // final step of the fixed schedule
    localparam step_t LAST_STEP = 5'd25;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } sched_state_t;

    // clear zeroes the sums, run marks a live step
    typedef struct packed {
        logic clear;
        logic run;
    } sched_ctrl_t;

    typedef struct packed {
        acc_t acc3;
        acc_t acc2;
        acc_t acc1;
        acc_t acc0;
    } acc_set_t;

endpackage

`default_nettype wire
